// File: rtl/pc_addr_pkg.sv
`default_nettype none

package pc_addr_pkg;

  //////////////////////////////
  // Address types
  //////////////////////////////

  // Program counter, jump and branch targets, CSR and pin addresses
  typedef logic [31:0] pc_t;

  // Upper part of mtvec
  // Vector address is this base followed by MTVEC_LSB_W zero bits
  typedef logic [23:0] mtvec_base_t;

  // Number of zero bits appended below the mtvec base
  localparam int unsigned MTVEC_LSB_W = 8;

  //////////////////////////////
  // Sequential step sizes
  //////////////////////////////

  // Inserted (dummy) instruction, PC stays put
  localparam pc_t STEP_NONE       = 32'd0;
  // 16-bit compressed encoding
  localparam pc_t STEP_COMPRESSED = 32'd2;
  // Full 32-bit encoding
  localparam pc_t STEP_FULL       = 32'd4;

  //////////////////////////////
  // Instruction metadata
  //////////////////////////////

  // Travels with the instruction in the IF/ID register
  typedef struct packed {
    logic dummy;       // Inserted instruction, step of 0
    logic compressed;  // Step of 2 when set, else 4
  } instr_meta_t;

endpackage

`default_nettype wire

// File: rtl/pc_alert.sv
`timescale 1ns/10ps
`default_nettype none

module pc_alert #(
  parameter int unsigned ERR_CNT_W = 8
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             err_i,
  input  wire logic             alert_clr_i,
  output logic                  alert_o,
  output logic [ERR_CNT_W-1:0]  err_count_o
);

  // Error count word
  typedef logic [ERR_CNT_W-1:0] err_cnt_t;

  // Count holds here once reached
  localparam err_cnt_t CNT_MAX = '1;

  //////////////////////////////
  // Alert level and counter
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alert_o     <= 1'b0;
      err_count_o <= '0;
    end else if (alert_clr_i) begin
      // Software clear beats a same-cycle error
      alert_o     <= 1'b0;
      err_count_o <= '0;
    end else if (err_i) begin
      alert_o <= 1'b1;
      // Saturate instead of wrapping
      if (err_count_o != CNT_MAX) begin
        err_count_o <= err_count_o + err_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/pc_check.sv
`timescale 1ns/10ps
`default_nettype none

module pc_check (
  pc_event_if.check                   ev_i,
  // Fetch and ID state
  input  wire pc_addr_pkg::pc_t         pc_if_i,
  input  wire pc_addr_pkg::pc_t         id_pc_i,
  input  wire pc_addr_pkg::instr_meta_t id_meta_i,
  // Control flow targets
  input  wire pc_addr_pkg::pc_t         jump_target_id_i,
  input  wire pc_addr_pkg::pc_t         branch_target_ex_i,
  input  wire pc_addr_pkg::pc_t         mepc_i,
  input  wire pc_addr_pkg::mtvec_base_t mtvec_base_i,
  input  wire pc_addr_pkg::pc_t         dpc_i,
  input  wire pc_addr_pkg::pc_t         boot_addr_i,
  input  wire pc_addr_pkg::pc_t         dm_halt_addr_i,
  input  wire pc_addr_pkg::pc_t         dm_exception_addr_i,
  input  wire pc_addr_pkg::pc_t         nmi_addr_i,
  // Second operation decisions
  input  wire logic                     jump_in_id_i,
  input  wire logic                     jump_taken_id_i,
  input  wire logic                     branch_in_ex_i,
  input  wire logic                     branch_taken_ex_i,
  input  wire logic                     branch_decision_ex_i,
  input  wire logic                     last_op_id_i,
  input  wire logic                     last_op_ex_i,
  output logic                          err_o
);
  import pc_addr_pkg::*;
  import pc_ctrl_pkg::*;

  pc_t  step;
  pc_t  incr_addr;
  pc_t  ctrl_flow_addr;
  pc_t  check_addr;
  logic addr_err;
  logic taken_err;
  logic untaken_err;

  //////////////////////////////
  // Expected fetch PC
  //////////////////////////////

  // Sequential step from the ID instruction
  assign step      = id_meta_i.dummy      ? STEP_NONE       :
                     id_meta_i.compressed ? STEP_COMPRESSED : STEP_FULL;
  assign incr_addr = id_pc_i + step;

  // Target picked by the registered mux source
  // A corrupted mux select lands on a wrong target and shows as addr_err
  always_comb begin
    case (ev_i.pc_mux_q)
      PC_JUMP:     ctrl_flow_addr = jump_target_id_i;
      PC_MRET:     ctrl_flow_addr = mepc_i;
      PC_BRANCH:   ctrl_flow_addr = branch_target_ex_i;
      PC_TRAP_DBD: ctrl_flow_addr = dm_halt_addr_i;
      PC_TRAP_DBE: ctrl_flow_addr = dm_exception_addr_i;
      PC_TRAP_NMI: ctrl_flow_addr = nmi_addr_i;
      PC_TRAP_EXC: ctrl_flow_addr = {mtvec_base_i, {MTVEC_LSB_W{1'b0}}};
      PC_DRET:     ctrl_flow_addr = dpc_i;
      default:     ctrl_flow_addr = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  // Halfword aligned fetch, bit 0 of a target never reaches IF
  assign check_addr = ev_i.pc_set_q ? {ctrl_flow_addr[31:1], 1'b0} : incr_addr;

  // Only meaningful right after a PC set or an IF to ID transfer
  assign addr_err = (ev_i.pc_set_q || ev_i.if_id_q) && (check_addr != pc_if_i);

  //////////////////////////////
  // Decision check
  //////////////////////////////

  // Taken first operation must be confirmed for as long as the flag holds
  assign taken_err = (ev_i.jmp_taken_q && !jump_in_id_i) ||
                     (ev_i.bch_taken_q && !(branch_in_ex_i && branch_decision_ex_i));

  // Second operation taken without a taken first one
  assign untaken_err = (!ev_i.jmp_taken_q && jump_taken_id_i && last_op_id_i) ||
                       (!ev_i.bch_taken_q && branch_taken_ex_i &&
                        branch_decision_ex_i && last_op_ex_i);

  // Quiet until the first PC set after reset
  assign err_o = (addr_err || taken_err || untaken_err) && ev_i.compare_en_q;

endmodule

`default_nettype wire

// File: rtl/pc_ctrl_pkg.sv
`default_nettype none

package pc_ctrl_pkg;

  //////////////////////////////
  // PC mux source
  //////////////////////////////

  // Source selected by the controller on a PC set
  typedef enum logic [3:0] {
    PC_BOOT     = 4'b0000,
    PC_JUMP     = 4'b0010,
    PC_BRANCH   = 4'b0011,
    PC_WB_PLUS4 = 4'b0100,
    PC_TRAP_EXC = 4'b0101,
    PC_TRAP_IRQ = 4'b0110,
    PC_TRAP_DBD = 4'b0111,
    PC_TRAP_DBE = 4'b1000,
    PC_MRET     = 4'b1001,
    PC_DRET     = 4'b1010,
    PC_TRAP_NMI = 4'b1011
  } pc_mux_e;

  // Sources whose target the monitor can rebuild from its inputs
  // WB plus 4 and interrupt targets are not visible here
  function automatic logic pc_src_recomputable(pc_mux_e src);
    logic not_visible;
    not_visible = (src == PC_WB_PLUS4) || (src == PC_TRAP_IRQ);
    return !not_visible;
  endfunction

endpackage

`default_nettype wire

// File: rtl/pc_event_capture.sv
`timescale 1ns/10ps
`default_nettype none

module pc_event_capture (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // Stage handshake levels
  input  wire logic                if_valid_i,
  input  wire logic                id_ready_i,
  input  wire logic                id_valid_i,
  input  wire logic                ex_ready_i,
  // Controller
  input  wire logic                pc_set_i,
  input  wire pc_ctrl_pkg::pc_mux_e pc_mux_i,
  input  wire logic                kill_id_i,
  input  wire logic                kill_ex_i,
  // Second operation of a split instruction is done
  input  wire logic                last_op_id_i,
  input  wire logic                last_op_ex_i,
  // Registered events towards the check
  pc_event_if.capture              ev_o
);
  import pc_ctrl_pkg::*;

  // Decoded controller events
  logic jmp_set;
  logic bch_set;
  logic jmp_clr;
  logic bch_clr;

  // Jump and mret are taken from ID, branches from EX
  assign jmp_set = pc_set_i && ((pc_mux_i == PC_JUMP) || (pc_mux_i == PC_MRET));
  assign bch_set = pc_set_i && (pc_mux_i == PC_BRANCH);

  // Flag drops once the last operation moves on, or its stage is flushed
  assign jmp_clr = (id_valid_i && ex_ready_i && last_op_id_i) || kill_id_i;
  assign bch_clr = (id_valid_i && ex_ready_i && last_op_ex_i) || kill_ex_i;

  //////////////////////////////
  // Event registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ev_o.pc_set_q     <= 1'b0;
      ev_o.pc_mux_q     <= PC_BOOT;
      ev_o.if_id_q      <= 1'b0;
      ev_o.compare_en_q <= 1'b0;
      ev_o.jmp_taken_q  <= 1'b0;
      ev_o.bch_taken_q  <= 1'b0;
    end else begin
      // Only sets with a known target take part in the address compare
      ev_o.pc_set_q <= pc_set_i && pc_src_recomputable(pc_mux_i);

      // Sequential step check follows each IF to ID transfer
      ev_o.if_id_q  <= if_valid_i && id_ready_i;

      // Mux source and compare enable on any PC set
      if (pc_set_i) begin
        ev_o.pc_mux_q     <= pc_mux_i;
        ev_o.compare_en_q <= 1'b1;
      end

      // Jump flag, clear wins over set
      if (jmp_clr) begin
        ev_o.jmp_taken_q <= 1'b0;
      end else if (jmp_set) begin
        ev_o.jmp_taken_q <= 1'b1;
      end

      // Branch flag, same priority
      if (bch_clr) begin
        ev_o.bch_taken_q <= 1'b0;
      end else if (bch_set) begin
        ev_o.bch_taken_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/pc_event_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pc_event_if;
  import pc_ctrl_pkg::*;

  // Recomputable PC set in the previous cycle
  logic    pc_set_q;
  // Mux source of the last PC set
  pc_mux_e pc_mux_q;
  // IF to ID transfer in the previous cycle
  logic    if_id_q;
  // Sticky, high from the first PC set after reset
  logic    compare_en_q;
  // Taken jump or mret, held until its second operation leaves ID
  logic    jmp_taken_q;
  // Taken branch, held until its second operation leaves EX
  logic    bch_taken_q;

  // Event capture side
  modport capture (
    output pc_set_q, pc_mux_q, if_id_q, compare_en_q, jmp_taken_q, bch_taken_q
  );

  // PC check side
  modport check (
    input pc_set_q, pc_mux_q, if_id_q, compare_en_q, jmp_taken_q, bch_taken_q
  );

endinterface

`default_nettype wire

// File: rtl/pc_guard_top.sv
`timescale 1ns/10ps
`default_nettype none

module pc_guard_top #(
  parameter int unsigned ERR_CNT_W = 8
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  // Pipeline and stage
  input  wire logic                     if_valid_i,
  input  wire logic                     id_ready_i,
  input  wire logic                     id_valid_i,
  input  wire logic                     ex_ready_i,
  input  wire pc_addr_pkg::pc_t         pc_if_i,
  input  wire pc_addr_pkg::pc_t         id_pc_i,
  input  wire pc_addr_pkg::instr_meta_t id_meta_i,
  // Controller
  input  wire logic                     pc_set_i,
  input  wire pc_ctrl_pkg::pc_mux_e     pc_mux_i,
  input  wire logic                     kill_id_i,
  input  wire logic                     kill_ex_i,
  input  wire logic                     jump_in_id_i,
  input  wire logic                     jump_taken_id_i,
  input  wire logic                     branch_in_ex_i,
  input  wire logic                     branch_taken_ex_i,
  // EX and last operation
  input  wire logic                     branch_decision_ex_i,
  input  wire logic                     last_op_id_i,
  input  wire logic                     last_op_ex_i,
  // Targets
  input  wire pc_addr_pkg::pc_t         jump_target_id_i,
  input  wire pc_addr_pkg::pc_t         branch_target_ex_i,
  input  wire pc_addr_pkg::pc_t         mepc_i,
  input  wire pc_addr_pkg::mtvec_base_t mtvec_base_i,
  input  wire pc_addr_pkg::pc_t         dpc_i,
  input  wire pc_addr_pkg::pc_t         boot_addr_i,
  input  wire pc_addr_pkg::pc_t         dm_halt_addr_i,
  input  wire pc_addr_pkg::pc_t         dm_exception_addr_i,
  input  wire pc_addr_pkg::pc_t         nmi_addr_i,
  // Alert
  input  wire logic                     alert_clr_i,
  output logic                          pc_err_o,
  output logic                          alert_o,
  output logic [ERR_CNT_W-1:0]          err_count_o
);

  // Registered controller events, capture to check
  pc_event_if ev_if ();

  //////////////////////////////
  // Input side
  //////////////////////////////

  pc_event_capture pc_event_capture_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_valid_i   (if_valid_i),
    .id_ready_i   (id_ready_i),
    .id_valid_i   (id_valid_i),
    .ex_ready_i   (ex_ready_i),
    .pc_set_i     (pc_set_i),
    .pc_mux_i     (pc_mux_i),
    .kill_id_i    (kill_id_i),
    .kill_ex_i    (kill_ex_i),
    .last_op_id_i (last_op_id_i),
    .last_op_ex_i (last_op_ex_i),
    .ev_o         (ev_if.capture)
  );

  //////////////////////////////
  // PC and decision check
  //////////////////////////////

  // Raw error goes straight out and into the alert block
  pc_check pc_check_i (
    .ev_i                 (ev_if.check),
    .pc_if_i              (pc_if_i),
    .id_pc_i              (id_pc_i),
    .id_meta_i            (id_meta_i),
    .jump_target_id_i     (jump_target_id_i),
    .branch_target_ex_i   (branch_target_ex_i),
    .mepc_i               (mepc_i),
    .mtvec_base_i         (mtvec_base_i),
    .dpc_i                (dpc_i),
    .boot_addr_i          (boot_addr_i),
    .dm_halt_addr_i       (dm_halt_addr_i),
    .dm_exception_addr_i  (dm_exception_addr_i),
    .nmi_addr_i           (nmi_addr_i),
    .jump_in_id_i         (jump_in_id_i),
    .jump_taken_id_i      (jump_taken_id_i),
    .branch_in_ex_i       (branch_in_ex_i),
    .branch_taken_ex_i    (branch_taken_ex_i),
    .branch_decision_ex_i (branch_decision_ex_i),
    .last_op_id_i         (last_op_id_i),
    .last_op_ex_i         (last_op_ex_i),
    .err_o                (pc_err_o)
  );

  //////////////////////////////
  // Output side
  //////////////////////////////

  pc_alert #(
    .ERR_CNT_W (ERR_CNT_W)
  ) pc_alert_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .err_i       (pc_err_o),
    .alert_clr_i (alert_clr_i),
    .alert_o     (alert_o),
    .err_count_o (err_count_o)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, verdict from the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f tb.f --top-module pc_guard_tb \
  --Mdir obj_dir -o pc_guard_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/pc_guard_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0

// File: tb.f
rtl/pc_addr_pkg.sv
rtl/pc_ctrl_pkg.sv
rtl/pc_event_if.sv
rtl/pc_event_capture.sv
rtl/pc_check.sv
rtl/pc_alert.sv
rtl/pc_guard_top.sv
verif/pc_guard_tb.sv

// File: verif/pc_guard_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pc_guard_tb;
  import pc_addr_pkg::*;
  import pc_ctrl_pkg::*;

  localparam int unsigned ERR_CNT_W  = 8;
  // About four times the length of all tests together
  localparam int          MAX_CYCLES = 2000;

  typedef logic [ERR_CNT_W-1:0] cnt_t;

  logic           clk;
  logic           rst_n;
  logic           if_valid_i, id_ready_i, id_valid_i, ex_ready_i;
  pc_t            pc_if_i, id_pc_i;
  instr_meta_t    id_meta_i;
  logic           pc_set_i;
  pc_mux_e        pc_mux_i;
  logic           kill_id_i, kill_ex_i;
  logic           jump_in_id_i, jump_taken_id_i, branch_in_ex_i, branch_taken_ex_i;
  logic           branch_decision_ex_i, last_op_id_i, last_op_ex_i;
  pc_t            jump_target_id_i, branch_target_ex_i, mepc_i, dpc_i, boot_addr_i;
  mtvec_base_t    mtvec_base_i;
  pc_t            dm_halt_addr_i, dm_exception_addr_i, nmi_addr_i;
  logic           alert_clr_i;
  logic           pc_err_o;
  logic           alert_o;
  cnt_t           err_count_o;

  int             cycles;
  int             errors;
  int             test_errs;
  int             tests_run;
  int             tests_failed;
  int unsigned    seed_init;

  pc_guard_top #(
    .ERR_CNT_W (ERR_CNT_W)
  ) pc_guard_top_i (.*);

  //////////////////////////////
  // Clock and run limit
  //////////////////////////////

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Sequential step where dummy wins over compressed
  function automatic pc_t step_for(instr_meta_t meta);
    if (meta.dummy) begin
      return 32'd0;
    end
    return meta.compressed ? 32'd2 : 32'd4;
  endfunction

  // Fetch PC expected after a set from this source
  function automatic pc_t target_for(pc_mux_e src);
    pc_t t;
    case (src)
      PC_JUMP:     t = {jump_target_id_i[31:1], 1'b0};
      PC_MRET:     t = {mepc_i[31:1], 1'b0};
      PC_BRANCH:   t = {branch_target_ex_i[31:1], 1'b0};
      PC_TRAP_DBD: t = {dm_halt_addr_i[31:1], 1'b0};
      PC_TRAP_DBE: t = {dm_exception_addr_i[31:1], 1'b0};
      PC_TRAP_NMI: t = {nmi_addr_i[31:1], 1'b0};
      PC_TRAP_EXC: t = {mtvec_base_i, 8'h00};
      PC_DRET:     t = {dpc_i[31:1], 1'b0};
      default:     t = {boot_addr_i[31:2], 2'b00};
    endcase
    return t;
  endfunction

  function automatic instr_meta_t meta_of(logic dummy, logic compressed);
    instr_meta_t m;
    m.dummy      = dummy;
    m.compressed = compressed;
    return m;
  endfunction

  //////////////////////////////
  // Drive and check helpers
  //////////////////////////////

  // Strobes and levels low while data inputs keep their values
  task automatic drive_idle();
    pc_set_i             = 1'b0;
    pc_mux_i             = PC_BOOT;
    if_valid_i           = 1'b0;
    id_ready_i           = 1'b0;
    id_valid_i           = 1'b0;
    ex_ready_i           = 1'b0;
    kill_id_i            = 1'b0;
    kill_ex_i            = 1'b0;
    jump_in_id_i         = 1'b0;
    jump_taken_id_i      = 1'b0;
    branch_in_ex_i       = 1'b0;
    branch_taken_ex_i    = 1'b0;
    branch_decision_ex_i = 1'b0;
    last_op_id_i         = 1'b0;
    last_op_ex_i         = 1'b0;
    alert_clr_i          = 1'b0;
  endtask

  // Odd low bits on purpose so the alignment rules matter
  task automatic random_targets();
    logic [31:0] r;
    jump_target_id_i    = $urandom;
    branch_target_ex_i  = $urandom;
    mepc_i              = $urandom;
    dpc_i               = $urandom;
    boot_addr_i         = $urandom;
    dm_halt_addr_i      = $urandom;
    dm_exception_addr_i = $urandom;
    nmi_addr_i          = $urandom;
    r                   = $urandom;
    mtvec_base_i        = r[23:0];
  endtask

  task automatic note_fail();
    errors++;
    test_errs++;
  endtask

  // Sampled 1 ns after the falling edge drive
  task automatic check_err(input logic exp, input string msg);
    #1;
    if (pc_err_o !== exp) begin
      $display("FAIL %0t: %s, pc_err_o %b expected %b", $time, msg, pc_err_o, exp);
      note_fail();
    end
  endtask

  task automatic check_alert(input logic exp_alert, input int exp_cnt, input string msg);
    #1;
    if (alert_o !== exp_alert || err_count_o !== cnt_t'(exp_cnt)) begin
      $display("FAIL %0t: %s, alert_o %b count %0d expected %b and %0d", $time, msg,
               alert_o, err_count_o, exp_alert, exp_cnt);
      note_fail();
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // Transfer in one cycle and compare against the fetch PC in the next
  task automatic seq_case(input pc_t pc, input instr_meta_t meta, input logic wrong,
                          input logic exp, input string msg);
    @(negedge clk);
    drive_idle();
    if_valid_i = 1'b1;
    id_ready_i = 1'b1;
    @(negedge clk);
    drive_idle();
    id_pc_i   = pc;
    id_meta_i = meta;
    pc_if_i   = pc + step_for(meta) + (wrong ? 32'd2 : 32'd0);
    check_err(exp, msg);
  endtask

  // PC set followed by a compare with decisions confirmed and flags killed
  task automatic pc_set_case(input pc_mux_e src, input logic flip, input logic exp);
    @(negedge clk);
    drive_idle();
    random_targets();
    pc_set_i = 1'b1;
    pc_mux_i = src;
    @(negedge clk);
    drive_idle();
    pc_if_i              = target_for(src) ^ (flip ? 32'h20 : 32'h0);
    jump_in_id_i         = 1'b1;
    branch_in_ex_i       = 1'b1;
    branch_decision_ex_i = 1'b1;
    kill_id_i            = 1'b1;
    kill_ex_i            = 1'b1;
    check_err(exp, $sformatf("target of %s flip %b", src.name(), flip));
    @(negedge clk);
    drive_idle();
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_and_gating();
    check_alert(1'b0, 0, "alert state after reset");
    check_err(1'b0, "raw error after reset");
    // Mismatching transfer before any PC set
    @(negedge clk);
    if_valid_i = 1'b1;
    id_ready_i = 1'b1;
    @(negedge clk);
    drive_idle();
    id_pc_i         = 32'h0000_0100;
    pc_if_i         = 32'h0000_dead;
    jump_taken_id_i = 1'b1;
    last_op_id_i    = 1'b1;
    check_err(1'b0, "errors gated before first PC set");
    report_test("reset and gating");
  endtask

  task automatic sequential_pc();
    @(negedge clk);
    drive_idle();
    boot_addr_i = 32'h0000_0080;
    pc_set_i    = 1'b1;
    pc_mux_i    = PC_BOOT;
    @(negedge clk);
    drive_idle();
    pc_if_i = 32'h0000_0080;
    check_err(1'b0, "boot target after first set");
    seq_case(32'h0000_0080, meta_of(1'b0, 1'b0), 1'b0, 1'b0, "step of 4");
    seq_case(32'h0000_0084, meta_of(1'b0, 1'b1), 1'b0, 1'b0, "compressed step of 2");
    seq_case(32'h0000_0086, meta_of(1'b1, 1'b0), 1'b0, 1'b0, "dummy step of 0");
    seq_case(32'h0000_0086, meta_of(1'b1, 1'b1), 1'b0, 1'b0, "dummy over compressed");
    seq_case(32'h0000_0086, meta_of(1'b0, 1'b1), 1'b1, 1'b1, "wrong sequential PC");
    report_test("sequential PC");
  endtask

  task automatic control_flow_targets();
    pc_mux_e srcs [9];
    srcs = '{PC_BOOT, PC_JUMP, PC_MRET, PC_BRANCH, PC_TRAP_DBD,
             PC_TRAP_DBE, PC_TRAP_NMI, PC_TRAP_EXC, PC_DRET};
    foreach (srcs[i]) begin
      pc_set_case(srcs[i], 1'b0, 1'b0);
      pc_set_case(srcs[i], 1'b1, 1'b1);
    end
    // Targets the monitor cannot rebuild are never compared
    pc_set_case(PC_TRAP_IRQ, 1'b1, 1'b0);
    pc_set_case(PC_WB_PLUS4, 1'b1, 1'b0);
    report_test("control flow targets");
  endtask

  task automatic taken_decisions();
    // Jump flag
    @(negedge clk);
    drive_idle();
    random_targets();
    pc_set_i = 1'b1;
    pc_mux_i = PC_JUMP;
    @(negedge clk);
    drive_idle();
    pc_if_i      = target_for(PC_JUMP);
    jump_in_id_i = 1'b1;
    check_err(1'b0, "jump confirmed in ID");
    repeat (2) begin
      @(negedge clk);
      check_err(1'b0, "jump held through stall");
    end
    @(negedge clk);
    jump_in_id_i = 1'b0;
    check_err(1'b1, "jump dropped while flag set");
    @(negedge clk);
    jump_in_id_i = 1'b1;
    id_valid_i   = 1'b1;
    ex_ready_i   = 1'b1;
    last_op_id_i = 1'b1;
    check_err(1'b0, "jump last operation leaves ID");
    @(negedge clk);
    drive_idle();
    check_err(1'b0, "jump flag cleared");
    // Branch flag
    @(negedge clk);
    random_targets();
    pc_set_i = 1'b1;
    pc_mux_i = PC_BRANCH;
    @(negedge clk);
    drive_idle();
    pc_if_i              = target_for(PC_BRANCH);
    branch_in_ex_i       = 1'b1;
    branch_decision_ex_i = 1'b1;
    check_err(1'b0, "branch confirmed in EX");
    @(negedge clk);
    check_err(1'b0, "branch held through stall");
    @(negedge clk);
    branch_decision_ex_i = 1'b0;
    check_err(1'b1, "branch decision dropped while flag set");
    @(negedge clk);
    branch_decision_ex_i = 1'b1;
    kill_ex_i            = 1'b1;
    check_err(1'b0, "branch killed in EX");
    @(negedge clk);
    drive_idle();
    check_err(1'b0, "branch flag cleared");
    report_test("taken decisions");
  endtask

  task automatic untaken_decisions();
    @(negedge clk);
    drive_idle();
    jump_taken_id_i = 1'b1;
    check_err(1'b0, "taken jump before its last operation");
    @(negedge clk);
    last_op_id_i = 1'b1;
    check_err(1'b1, "taken jump without prior set");
    @(negedge clk);
    drive_idle();
    branch_taken_ex_i    = 1'b1;
    branch_decision_ex_i = 1'b1;
    last_op_ex_i         = 1'b1;
    check_err(1'b1, "taken branch without prior set");
    @(negedge clk);
    drive_idle();
    check_err(1'b0, "quiet after untaken checks");
    report_test("untaken decisions");
  endtask

  task automatic alert_counter();
    int exp_cnt;
    int sat_cnt;
    int held;
    sat_cnt = (1 << ERR_CNT_W) - 1;
    held    = sat_cnt + 4;
    @(negedge clk);
    drive_idle();
    alert_clr_i = 1'b1;
    @(negedge clk);
    drive_idle();
    check_alert(1'b0, 0, "alert cleared");
    exp_cnt = 0;
    repeat (3) begin
      @(negedge clk);
      jump_taken_id_i = 1'b1;
      last_op_id_i    = 1'b1;
      check_err(1'b1, "forced untaken error");
      @(negedge clk);
      drive_idle();
      exp_cnt++;
      check_alert(1'b1, exp_cnt, "count after one error cycle");
    end
    // Clear and error in the same cycle
    @(negedge clk);
    alert_clr_i     = 1'b1;
    jump_taken_id_i = 1'b1;
    last_op_id_i    = 1'b1;
    @(negedge clk);
    drive_idle();
    check_alert(1'b0, 0, "clear wins over error");
    // Continuous errors past the top of the counter
    @(negedge clk);
    jump_taken_id_i = 1'b1;
    last_op_id_i    = 1'b1;
    repeat (held) @(negedge clk);
    drive_idle();
    check_alert(1'b1, sat_cnt, "saturated count");
    @(negedge clk);
    alert_clr_i = 1'b1;
    @(negedge clk);
    drive_idle();
    check_alert(1'b0, 0, "clear after saturation");
    report_test("alert counter");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    $timeformat(-9, 1, " ns", 0);
    seed_init    = $urandom(32'h6a);
    clk          = 1'b0;
    rst_n        = 1'b0;
    cycles       = 0;
    errors       = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    drive_idle();
    pc_if_i             = '0;
    id_pc_i             = '0;
    id_meta_i           = meta_of(1'b0, 1'b0);
    jump_target_id_i    = '0;
    branch_target_ex_i  = '0;
    mepc_i              = '0;
    mtvec_base_i        = '0;
    dpc_i               = '0;
    boot_addr_i         = '0;
    dm_halt_addr_i      = '0;
    dm_exception_addr_i = '0;
    nmi_addr_i          = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_and_gating();
    sequential_pc();
    control_flow_targets();
    taken_decisions();
    untaken_decisions();
    alert_counter();

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
